// ==== data_cache.f ====
+incdir+include
hw/cache_pkg.sv
hw/set_way_ram.sv
hw/tag_lookup.sv
hw/replacement_ctrl.sv
hw/way_data_store.sv
hw/data_cache_top.sv
verification/data_cache_tb.sv

// ==== Bender.yml ====
package:
  name: data_cache

export_include_dirs:
  - include

sources:
  - files:
      - hw/cache_pkg.sv
      - hw/set_way_ram.sv
      - hw/tag_lookup.sv
      - hw/replacement_ctrl.sv
      - hw/way_data_store.sv
      - hw/data_cache_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - verification/data_cache_tb.sv

// ==== include/data_cache_tb_table.svh ====
// Data cache testbench table
// One cache operation per row, with the stall and read data it should produce

`ifndef DATA_CACHE_TB_TABLE_SVH
`define DATA_CACHE_TB_TABLE_SVH

// Columns: write, addr, byte_en, writedata, refill word, stall expected, readdata expected
// Sets 1 and 2 hold the basic and merge cases, set 5 the replacement sequence
task automatic load_table();
    // Cold read miss in set 1, then the same word hits
    set_entry(1'b0, 32'h0000_0204, 4'hf, 32'h0000_0000, 32'h1111_2222, 1'b1, 32'h1111_2222);
    set_entry(1'b0, 32'h0000_0204, 4'hf, 32'h0000_0000, 32'hdead_beef, 1'b0, 32'h1111_2222);
    // Full-word write miss fills at once
    set_entry(1'b1, 32'h0000_0224, 4'hf, 32'hcafe_f00d, 32'hdead_beef, 1'b0, 32'h0000_0000);
    set_entry(1'b0, 32'h0000_0224, 4'hf, 32'h0000_0000, 32'hdead_beef, 1'b0, 32'hcafe_f00d);
    // Partial write hit, low half only
    set_entry(1'b1, 32'h0000_0224, 4'h3, 32'h1234_5678, 32'hdead_beef, 1'b0, 32'h0000_0000);
    set_entry(1'b0, 32'h0000_0224, 4'hf, 32'h0000_0000, 32'hdead_beef, 1'b0, 32'hcafe_5678);
    // Partial write miss in set 2, bytes 3 and 1 over the refill word
    set_entry(1'b1, 32'h0000_0248, 4'ha, 32'haabb_ccdd, 32'h0102_0304, 1'b1, 32'h0000_0000);
    set_entry(1'b0, 32'h0000_0248, 4'hf, 32'h0000_0000, 32'hdead_beef, 1'b0, 32'haa02_cc04);
    // Set 5, tags 0x20 to 0x23 fill ways 0 to 3
    set_entry(1'b0, 32'h0000_0414, 4'hf, 32'h0000_0000, 32'ha0a0_0001, 1'b1, 32'ha0a0_0001);
    set_entry(1'b0, 32'h0000_0434, 4'hf, 32'h0000_0000, 32'hb0b0_0002, 1'b1, 32'hb0b0_0002);
    set_entry(1'b0, 32'h0000_0454, 4'hf, 32'h0000_0000, 32'hc0c0_0003, 1'b1, 32'hc0c0_0003);
    set_entry(1'b0, 32'h0000_0474, 4'hf, 32'h0000_0000, 32'hd0d0_0004, 1'b1, 32'hd0d0_0004);
    // Touch way 0 then way 2, tree leaves way 1 as the victim
    set_entry(1'b0, 32'h0000_0414, 4'hf, 32'h0000_0000, 32'hdead_beef, 1'b0, 32'ha0a0_0001);
    set_entry(1'b0, 32'h0000_0454, 4'hf, 32'h0000_0000, 32'hdead_beef, 1'b0, 32'hc0c0_0003);
    // Tag 0x24 replaces tag 0x21 in way 1
    set_entry(1'b0, 32'h0000_0494, 4'hf, 32'h0000_0000, 32'he0e0_0005, 1'b1, 32'he0e0_0005);
    // Other residents still hit
    set_entry(1'b0, 32'h0000_0414, 4'hf, 32'h0000_0000, 32'hdead_beef, 1'b0, 32'ha0a0_0001);
    set_entry(1'b0, 32'h0000_0454, 4'hf, 32'h0000_0000, 32'hdead_beef, 1'b0, 32'hc0c0_0003);
    set_entry(1'b0, 32'h0000_0474, 4'hf, 32'h0000_0000, 32'hdead_beef, 1'b0, 32'hd0d0_0004);
    set_entry(1'b0, 32'h0000_0494, 4'hf, 32'h0000_0000, 32'hdead_beef, 1'b0, 32'he0e0_0005);
    // Evicted tag misses, lands in way 2 (root 0, upper leaf 1)
    set_entry(1'b0, 32'h0000_0434, 4'hf, 32'h0000_0000, 32'hb1b1_0012, 1'b1, 32'hb1b1_0012);
    // So tag 0x22 is gone now
    set_entry(1'b0, 32'h0000_0454, 4'hf, 32'h0000_0000, 32'hc1c1_0013, 1'b1, 32'hc1c1_0013);
endtask

`endif

// ==== verification/data_cache_tb.sv ====
// Data cache testbench
// Drives table rows of reads and writes with refill and checks stall and read data

`timescale 1ns/100ps

module data_cache_tb;

    localparam int clk_period       = 40;
    localparam int reset_cycles     = 4;
    localparam int refill_delay     = 2;  // Stalled cycles before data_valid
    localparam int cycles_per_entry = 8;  // Watchdog budget per row

    logic                clk;
    logic                rst;
    logic [31:0]         addr;
    logic                read_en;
    logic                write_en;
    cache_pkg::word_t    writedata;
    cache_pkg::byte_en_t byte_en;
    cache_pkg::word_t    data_in;
    logic                data_valid;
    cache_pkg::word_t    readdata;
    logic                stall;

    // Table columns with one entry per row
    bit                  tbl_write  [$];
    logic [31:0]         tbl_addr   [$];
    cache_pkg::byte_en_t tbl_be     [$];
    cache_pkg::word_t    tbl_wdata  [$];
    cache_pkg::word_t    tbl_refill [$];
    bit                  tbl_stall  [$];
    cache_pkg::word_t    tbl_rdata  [$];

    data_cache_top UUT (
        .clk        (clk),
        .rst        (rst),
        .addr       (addr),
        .read_en    (read_en),
        .write_en   (write_en),
        .writedata  (writedata),
        .byte_en    (byte_en),
        .data_in    (data_in),
        .data_valid (data_valid),
        .readdata   (readdata),
        .stall      (stall)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // Append one row
    task automatic set_entry(input bit is_write, input logic [31:0] a,
                             input cache_pkg::byte_en_t be, input cache_pkg::word_t wdata,
                             input cache_pkg::word_t refill, input bit exp_stall,
                             input cache_pkg::word_t exp_rdata);
        tbl_write.push_back(is_write);
        tbl_addr.push_back(a);
        tbl_be.push_back(be);
        tbl_wdata.push_back(wdata);
        tbl_refill.push_back(refill);
        tbl_stall.push_back(exp_stall);
        tbl_rdata.push_back(exp_rdata);
    endtask

    `include "data_cache_tb_table.svh"

    task automatic report_error(input string msg);
        $display("FAIL at %0d ns: %s", $time, msg);
        $display("SIMULATION FAILED");
        $fatal(1, "Stopped at first error");
    endtask

    task automatic drive_idle();
        read_en    = 1'b0;
        write_en   = 1'b0;
        data_valid = 1'b0;
    endtask

    // Starts on a falling edge and returns on the falling edge after the access completes
    task automatic apply_entry(input int i);
        int stalled;
        stalled    = 0;
        addr       = tbl_addr[i];
        read_en    = !tbl_write[i];
        write_en   = tbl_write[i];
        byte_en    = tbl_be[i];
        writedata  = tbl_wdata[i];
        data_in    = tbl_refill[i];
        data_valid = 1'b0;
        #1;  // Let the combinational stall settle
        assert (stall === tbl_stall[i])
        else report_error($sformatf("entry %0d stall %b, expected %b", i, stall, tbl_stall[i]));
        // Hold the request while memory answers after two stalled cycles
        while (stall === 1'b1) begin
            stalled++;
            @(negedge clk);
            data_valid = (stalled == refill_delay);
            #1;
        end
        if (tbl_stall[i]) begin
            assert (stalled == refill_delay + 1)
            else report_error($sformatf("entry %0d stalled %0d cycles", i, stalled));
        end
        @(negedge clk);  // Hit or fill taken on the edge just passed
        if (!tbl_write[i]) begin
            assert (readdata === tbl_rdata[i])
            else report_error($sformatf("entry %0d readdata %h, expected %h",
                                        i, readdata, tbl_rdata[i]));
        end
    endtask

    initial begin
        rst        = 1'b1;
        addr       = '0;
        read_en    = 1'b0;
        write_en   = 1'b0;
        writedata  = '0;
        byte_en    = '0;
        data_in    = '0;
        data_valid = 1'b0;
        load_table();

        // Watchdog sized from the table length
        fork
            begin
                #((tbl_addr.size() * cycles_per_entry + reset_cycles) * clk_period);
                $display("Timeout: the cache did not complete the table in time");
                $display("SIMULATION FAILED");
                $fatal(1, "Watchdog expired");
            end
        join_none

        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        #1;
        assert (stall === 1'b0) else report_error("stall high after reset with no request");
        assert (readdata === '0) else report_error($sformatf("readdata %h after reset", readdata));

        @(negedge clk);
        for (int i = 0; i < tbl_addr.size(); i++) begin
            apply_entry(i);
        end
        drive_idle();
        #1;
        assert (stall === 1'b0) else report_error("stall high with no request");

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

// ==== hw/data_cache_top.sv ====
// Data cache top
// 4-way set-associative write-allocate data cache, address split and block wiring

`timescale 1ns/100ps

module data_cache_top (
    input  logic                clk,
    input  logic                rst,
    input  logic [31:0]         addr,       // Byte address from the CPU
    input  logic                read_en,    // Held while stall is high
    input  logic                write_en,
    input  cache_pkg::word_t    writedata,
    input  cache_pkg::byte_en_t byte_en,
    input  cache_pkg::word_t    data_in,    // Refill word from memory controller
    input  logic                data_valid, // Strobe for data_in
    output cache_pkg::word_t    readdata,
    output logic                stall       // Also seen by the memory controller
);

    cache_pkg::set_idx_t set_idx;
    cache_pkg::tag_t     tag;
    logic                hit;
    cache_pkg::way_vec_t hit_ways;
    cache_pkg::way_vec_t valid_ways;
    logic                fill_en;
    logic                read_hit;
    logic                write_hit;
    cache_pkg::way_t     access_way;  // Hit way or victim

    // Word address split, bits 1:0 are the byte offset
    assign set_idx = addr[cache_pkg::set_bits+1:2];
    assign tag     = addr[31:cache_pkg::set_bits+2];

    tag_lookup u_tag_lookup (
        .clk        (clk),
        .rst        (rst),
        .set_idx    (set_idx),
        .tag        (tag),
        .fill_en    (fill_en),
        .access_way (access_way),
        .hit        (hit),
        .hit_ways   (hit_ways),
        .valid_ways (valid_ways)
    );

    replacement_ctrl u_replacement_ctrl (
        .clk        (clk),
        .rst        (rst),
        .set_idx    (set_idx),
        .read_en    (read_en),
        .write_en   (write_en),
        .byte_en    (byte_en),
        .data_valid (data_valid),
        .hit        (hit),
        .hit_ways   (hit_ways),
        .valid_ways (valid_ways),
        .stall      (stall),
        .fill_en    (fill_en),
        .read_hit   (read_hit),
        .write_hit  (write_hit),
        .access_way (access_way)
    );

    way_data_store u_way_data_store (
        .clk        (clk),
        .rst        (rst),
        .set_idx    (set_idx),
        .access_way (access_way),
        .fill_en    (fill_en),
        .read_hit   (read_hit),
        .write_hit  (write_hit),
        .read_en    (read_en),
        .byte_en    (byte_en),
        .writedata  (writedata),
        .data_in    (data_in),
        .readdata   (readdata)
    );

endmodule

// ==== hw/way_data_store.sv ====
// Way data store
// Data array with byte merge for fills and write hits, registered read data

`timescale 1ns/100ps

module way_data_store (
    input  logic                clk,
    input  logic                rst,
    input  cache_pkg::set_idx_t set_idx,
    input  cache_pkg::way_t     access_way,
    input  logic                fill_en,
    input  logic                read_hit,
    input  logic                write_hit,
    input  logic                read_en,
    input  cache_pkg::byte_en_t byte_en,
    input  cache_pkg::word_t    writedata,
    input  cache_pkg::word_t    data_in,
    output cache_pkg::word_t    readdata
);

    cache_pkg::word_t data_ways [cache_pkg::num_ways];  // Words of the current set
    cache_pkg::word_t hit_word;    // Word at access_way
    cache_pkg::word_t merge_base;  // Bytes kept where byte_en is low
    cache_pkg::word_t merged;      // writedata over merge_base
    cache_pkg::word_t wr_word;     // Final word into the array
    logic             data_wr_en;

    assign hit_word = data_ways[access_way];

    // Fill merges over the refill word, write hit over the stored line
    assign merge_base = fill_en ? data_in : hit_word;

    always_comb begin
        for (int b = 0; b < cache_pkg::word_bytes; b++) begin
            merged[b*8 +: 8] = byte_en[b] ? writedata[b*8 +: 8] : merge_base[b*8 +: 8];
        end
    end

    // Read fill takes the refill word whole
    assign wr_word    = (fill_en & read_en) ? data_in : merged;
    assign data_wr_en = fill_en | write_hit;

    set_way_ram #(
        .payload_t (cache_pkg::word_t)
    ) u_data_ram (
        .clk     (clk),
        .rst     (rst),
        .wr_en   (data_wr_en),
        .wr_set  (set_idx),
        .wr_way  (access_way),
        .wr_data (wr_word),
        .rd_set  (set_idx),
        .rd_ways (data_ways)
    );

    // Read hit word appears one edge later
    always_ff @(posedge clk) begin
        if (rst) begin
            readdata <= '0;
        end else if (read_hit) begin
            readdata <= hit_word;
        end
    end

endmodule

// ==== hw/replacement_ctrl.sv ====
// Replacement control
// Stall and access strobes, tree pseudo-LRU per set, victim choice

`timescale 1ns/100ps

module replacement_ctrl (
    input  logic                clk,
    input  logic                rst,
    input  cache_pkg::set_idx_t set_idx,
    input  logic                read_en,
    input  logic                write_en,
    input  cache_pkg::byte_en_t byte_en,
    input  logic                data_valid,
    input  logic                hit,
    input  cache_pkg::way_vec_t hit_ways,
    input  cache_pkg::way_vec_t valid_ways,
    output logic                stall,
    output logic                fill_en,
    output logic                read_hit,
    output logic                write_hit,
    output cache_pkg::way_t     access_way
);

    // Tree bits: [0] root, [1] leaf of ways 0/1, [2] leaf of ways 2/3
    logic [cache_pkg::num_ways-2:0] plru_q [cache_pkg::num_sets];
    logic [cache_pkg::num_ways-2:0] tree;  // Tree of the addressed set

    logic            request;     // Any CPU access
    logic            full_word;   // Write covering all four bytes
    logic            access;      // Hit or fill, updates the tree
    logic            lru_half;    // Half opposite the root
    logic            lru_leaf;    // Leaf bit of that half
    cache_pkg::way_t hit_way;
    cache_pkg::way_t lru_way;
    cache_pkg::way_t victim_way;

    assign request   = read_en | write_en;
    assign full_word = write_en & (&byte_en);

    // Partial write miss needs the line first, full word does not
    assign stall     = ~hit & (read_en | (write_en & ~(&byte_en)));
    assign fill_en   = request & ~hit & (data_valid | full_word);
    assign read_hit  = hit & read_en;
    assign write_hit = hit & write_en & ~read_en;  // Read wins if both raised
    assign access    = (hit & request) | fill_en;

    // One-hot hit vector to way number
    always_comb begin
        hit_way = '0;
        for (int w = 0; w < cache_pkg::num_ways; w++) begin
            if (hit_ways[w]) hit_way = cache_pkg::way_t'(w);
        end
    end

    assign tree     = plru_q[set_idx];
    assign lru_half = ~tree[0];                          // Root points at recent half
    assign lru_leaf = lru_half ? tree[2] : tree[1];
    assign lru_way  = {lru_half, ~lru_leaf};             // Sibling of recent way

    // Lowest invalid way first, tree only when the set is full
    always_comb begin
        victim_way = lru_way;
        if (!(&valid_ways)) begin
            for (int w = cache_pkg::num_ways - 1; w >= 0; w--) begin
                if (!valid_ways[w]) victim_way = cache_pkg::way_t'(w);
            end
        end
    end

    assign access_way = hit ? hit_way : victim_way;

    // Tree update on every hit or fill
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < cache_pkg::num_sets; s++) begin
                plru_q[s] <= '0;
            end
        end else if (access) begin
            plru_q[set_idx][0] <= access_way[1];      // Upper half if way 2 or 3
            if (access_way[1]) begin
                plru_q[set_idx][2] <= access_way[0];
            end else begin
                plru_q[set_idx][1] <= access_way[0];
            end
        end
    end

endmodule

// ==== hw/tag_lookup.sv ====
// Tag lookup
// Holds tags and valid bits per set, compares all four ways against the request tag

`timescale 1ns/100ps

module tag_lookup (
    input  logic                clk,
    input  logic                rst,
    input  cache_pkg::set_idx_t set_idx,
    input  cache_pkg::tag_t     tag,
    input  logic                fill_en,
    input  cache_pkg::way_t     access_way,
    output logic                hit,
    output cache_pkg::way_vec_t hit_ways,
    output cache_pkg::way_vec_t valid_ways
);

    cache_pkg::way_vec_t valid_q [cache_pkg::num_sets];  // Valid bit per way, per set
    cache_pkg::tag_t     tag_ways [cache_pkg::num_ways]; // Stored tags of the current set

    // Tag store, written only on a fill
    set_way_ram #(
        .payload_t (cache_pkg::tag_t)
    ) u_tag_ram (
        .clk     (clk),
        .rst     (rst),
        .wr_en   (fill_en),
        .wr_set  (set_idx),
        .wr_way  (access_way),
        .wr_data (tag),
        .rd_set  (set_idx),
        .rd_ways (tag_ways)
    );

    // Valid bits
    // A fill marks the victim way, nothing ever clears a bit except reset
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < cache_pkg::num_sets; s++) begin
                valid_q[s] <= '0;
            end
        end else if (fill_en) begin
            valid_q[set_idx][access_way] <= 1'b1;
        end
    end

    assign valid_ways = valid_q[set_idx];

    // Four comparators in parallel, gated by valid
    always_comb begin
        for (int w = 0; w < cache_pkg::num_ways; w++) begin
            hit_ways[w] = valid_ways[w] && (tag_ways[w] == tag);
        end
    end

    assign hit = |hit_ways;  // At most one way can match

endmodule

// ==== hw/set_way_ram.sv ====
// Set/way storage array
// One write port per cycle, combinational read of every way in one set

`timescale 1ns/100ps

module set_way_ram #(
    parameter type payload_t = cache_pkg::word_t  // Tag or data word
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                wr_en,
    input  cache_pkg::set_idx_t wr_set,
    input  cache_pkg::way_t     wr_way,
    input  payload_t            wr_data,
    input  cache_pkg::set_idx_t rd_set,
    output payload_t            rd_ways [cache_pkg::num_ways]
);

    payload_t mem [cache_pkg::num_sets][cache_pkg::num_ways];  // Register array

    // Single entry write
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < cache_pkg::num_sets; s++) begin
                for (int w = 0; w < cache_pkg::num_ways; w++) begin
                    mem[s][w] <= '0;
                end
            end
        end else if (wr_en) begin
            mem[wr_set][wr_way] <= wr_data;
        end
    end

    // All ways of the addressed set, same cycle
    always_comb begin
        for (int w = 0; w < cache_pkg::num_ways; w++) begin
            rd_ways[w] = mem[rd_set][w];
        end
    end

endmodule

// ==== hw/cache_pkg.sv ====
// Data cache package
// Geometry constants and the shared types of the 4-way, 8-set data cache

package cache_pkg;

    // Cache geometry
    localparam int num_ways   = 4;  // Ways per set
    localparam int num_sets   = 8;  // Sets, one word per line
    localparam int set_bits   = 3;  // Set index width
    localparam int way_bits   = 2;  // Way index width
    localparam int word_bytes = 4;  // Bytes per word

    // Tag is what remains above the set index and the 2 byte-offset bits
    localparam int tag_bits = 32 - set_bits - 2;

    // Set number, taken from address bits 4 to 2
    typedef logic [set_bits-1:0] set_idx_t;

    // Line tag, address bits 31 to 5
    typedef logic [tag_bits-1:0] tag_t;

    // Way number inside a set
    typedef logic [way_bits-1:0] way_t;

    // One bit per way
    // Used for hit and valid vectors
    typedef logic [num_ways-1:0] way_vec_t;

    // Data word as seen by the CPU and the memory controller
    typedef logic [word_bytes*8-1:0] word_t;

    // Byte enables, bit b covers byte lane b
    typedef logic [word_bytes-1:0] byte_en_t;

endpackage
